// File: tb.f
source/xpt_pkg.sv
source/axis_if.sv
source/axis_crosspoint.sv
source/frame_counter.sv
source/axil_switch_regs.sv
source/axis_switch_top.sv
bench/tb_clk_gen.sv
bench/tb_axis_switch.sv

// File: bench/tb_axis_switch.sv
`timescale 1ns/1ps

module tb_axis_switch;

    localparam int TIMEOUT = 50;

    logic        clk;
    logic        rst;
    logic [31:0] s_axis_tdata;
    logic [3:0]  s_axis_tvalid, s_axis_tlast, s_axis_tuser;
    logic [31:0] m_axis_tdata;
    logic [3:0]  m_axis_tvalid, m_axis_tlast, m_axis_tuser;
    logic [xpt_pkg::AXIL_ADDR_WIDTH-1:0] awaddr, araddr;
    logic        awvalid, awready, wvalid, wready, bvalid, bready;
    logic        arvalid, arready, rvalid, rready;
    logic [31:0] wdata, rdata;
    logic [3:0]  wstrb;
    logic [1:0]  bresp, rresp;

    // driven beats {tdata, tvalid, tlast, tuser}, index 0 is the newest
    logic [43:0] hist [3];
    logic [7:0]  exp_sel;
    int          exp_cnt [4];
    int          errors;
    logic        check_en;
    logic        traffic_on;
    logic [31:0] rng_dat;
    logic [31:0] rng_ctl;

    tb_clk_gen clk_gen_i (.clk(clk), .rst(rst));

    axis_switch_top #(.S_COUNT(4), .M_COUNT(4), .DATA_WIDTH(8), .USER_WIDTH(1)) dut_i (.*);

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // output m takes the whole beat of the input named by select field m
    function automatic logic [43:0] route_expected(input logic [43:0] beats,
                                                   input logic [7:0] sel);
        logic [43:0] r;
        int          src;
        r = '0;
        for (int m = 0; m < 4; m++) begin
            src = sel[2*m +: 2];
            r[12+8*m +: 8] = beats[12+8*src +: 8];
            r[8+m]         = beats[8+src];
            r[4+m]         = beats[4+src];
            r[m]           = beats[src];
        end
        return r;
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            errors++;
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("Timeout: waited %0d cycles for the %s, giving up", TIMEOUT, what);
        $display("Closing count: %0d errors and 1 timeout", errors);
        $display("Simulation FAILED");
        $finish;
    endtask

    // 0 awready, 1 bvalid, 2 arready, 3 rvalid
    function automatic logic axi_flag(input int which);
        case (which)
            0: return awready;
            1: return bvalid;
            2: return arready;
            default: return rvalid;
        endcase
    endfunction

    task automatic wait_for_flag(input int which, input string what);
        int t;
        for (t = 0; !axi_flag(which); t++) begin
            if (t == TIMEOUT)
                stop_on_timeout(what);
            else
                @(negedge clk);
        end
    endtask

    task automatic axil_write(input logic [xpt_pkg::AXIL_ADDR_WIDTH-1:0] addr,
                              input logic [31:0] data, input logic [3:0] strb,
                              input int hold, output logic [1:0] resp);
        @(posedge clk);
        #2;
        awaddr  = addr;
        wdata   = data;
        wstrb   = strb;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        @(negedge clk);
        wait_for_flag(0, "write address channel");
        check_value(wready, 1'b1, "wready with awready");
        @(posedge clk);
        #2;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        @(negedge clk);
        wait_for_flag(1, "write response channel");
        resp = bresp;
        repeat (hold) begin
            @(negedge clk);
            check_value(bvalid, 1'b1, "bvalid under back-pressure");
            check_value(bresp, resp, "bresp under back-pressure");
        end
        @(posedge clk);
        #2;
        bready = 1'b1;
        @(posedge clk);
        #2;
        bready = 1'b0;
    endtask

    task automatic axil_read(input logic [xpt_pkg::AXIL_ADDR_WIDTH-1:0] addr, input int hold,
                             output logic [31:0] data, output logic [1:0] resp);
        @(posedge clk);
        #2;
        araddr  = addr;
        arvalid = 1'b1;
        @(negedge clk);
        wait_for_flag(2, "read address channel");
        @(posedge clk);
        #2;
        arvalid = 1'b0;
        @(negedge clk);
        wait_for_flag(3, "read data channel");
        data = rdata;
        resp = rresp;
        repeat (hold) begin
            @(negedge clk);
            check_value(rvalid, 1'b1, "rvalid under back-pressure");
            check_value(rdata, data, "rdata under back-pressure");
            check_value(rresp, resp, "rresp under back-pressure");
        end
        @(posedge clk);
        #2;
        rready = 1'b1;
        @(posedge clk);
        #2;
        rready = 1'b0;
    endtask

    task automatic run_traffic(input int cycles);
        @(posedge clk);
        traffic_on = 1'b1;
        repeat (cycles) @(posedge clk);
        traffic_on = 1'b0;
        // let the pipeline drain
        repeat (4) @(posedge clk);
    endtask

    // streams must be idle here
    task automatic set_select(input logic [31:0] word, input logic [3:0] strb);
        logic [31:0] data;
        logic [1:0]  resp;
        check_en = 1'b0;
        axil_write(xpt_pkg::ADDR_SELECT, word, strb, 0, resp);
        check_value(resp, xpt_pkg::RESP_OKAY, "select write resp");
        if (strb[0])
            exp_sel = word[7:0];
        axil_read(xpt_pkg::ADDR_SELECT, 0, data, resp);
        check_value(data, {24'h0, exp_sel}, "select read back");
        check_value(resp, xpt_pkg::RESP_OKAY, "select read resp");
        repeat (8) @(posedge clk);
        check_en = 1'b1;
    endtask

    task automatic check_counters();
        logic [31:0] data;
        logic [1:0]  resp;
        for (int i = 0; i < 4; i++) begin
            axil_read(xpt_pkg::ADDR_CNT_BASE + 4*i, 0, data, resp);
            check_value(data, exp_cnt[i] & 32'hffff, $sformatf("frame count %0d", i));
            check_value(resp, xpt_pkg::RESP_OKAY, "counter read resp");
        end
    endtask

    // new input beat every cycle, idle when traffic is off
    always begin
        @(posedge clk);
        #2;
        rng_dat = xorshift(rng_dat);
        s_axis_tdata = rng_dat;
        rng_dat = xorshift(rng_dat);
        s_axis_tvalid = traffic_on ? rng_dat[3:0] : 4'h0;
        s_axis_tlast  = rng_dat[11:8];
        s_axis_tuser  = rng_dat[19:16];
        hist[2] = hist[1];
        hist[1] = hist[0];
        hist[0] = {s_axis_tdata, s_axis_tvalid, s_axis_tlast, s_axis_tuser};
    end

    always @(negedge clk) begin : compare
        logic [43:0] want;
        if (check_en) begin
            want = route_expected(hist[2], exp_sel);
            for (int m = 0; m < 4; m++) begin
                check_value(m_axis_tvalid[m], want[8+m], $sformatf("m%0d tvalid", m));
                if (want[8+m]) begin
                    check_value(m_axis_tdata[8*m +: 8], want[12+8*m +: 8],
                                $sformatf("m%0d tdata", m));
                    check_value(m_axis_tlast[m], want[4+m], $sformatf("m%0d tlast", m));
                    check_value(m_axis_tuser[m], want[m], $sformatf("m%0d tuser", m));
                    if (want[4+m])
                        exp_cnt[m]++;
                end
            end
        end
    end

    initial begin : main
        logic [31:0] word;
        logic [31:0] data;
        logic [1:0]  resp;
        int          t;
        {s_axis_tdata, s_axis_tvalid, s_axis_tlast, s_axis_tuser} = '0;
        {awaddr, awvalid, wdata, wstrb, wvalid, bready} = '0;
        {araddr, arvalid, rready} = '0;
        hist = '{default: '0};
        exp_cnt = '{default: 0};
        exp_sel = '0;
        errors = 0;
        check_en = 1'b0;
        traffic_on = 1'b0;
        rng_dat = 32'ha8a2;
        rng_ctl = 32'ha8a2;
        for (t = 0; rst !== 1'b0; t++) begin
            if (t == TIMEOUT)
                stop_on_timeout("reset release");
            else
                @(posedge clk);
        end
        repeat (3) @(negedge clk);
        check_value(m_axis_tvalid, 4'h0, "m tvalid after reset");
        check_value({awready, wready, arready, bvalid, rvalid}, 5'h0,
                    "AXI ready and valid after reset");
        check_en = 1'b1;
        axil_read(xpt_pkg::ADDR_SELECT, 0, data, resp);
        check_value(data, 32'h0, "select after reset");
        check_value(resp, xpt_pkg::RESP_OKAY, "select read resp");
        run_traffic(100);
        // random words, all from input 1, and two pairs sharing a source
        for (int k = 0; k < 5; k++) begin
            rng_ctl = xorshift(rng_ctl);
            word = (k == 1) ? 32'h0000_0055 : (k == 2) ? 32'hffff_ff5a : rng_ctl;
            set_select(word, 4'hf);
            run_traffic(150);
        end
        // low byte disabled, so routing stays put
        set_select(~{24'h0, exp_sel}, 4'b1110);
        run_traffic(60);
        set_select(32'hffff_ff1b, 4'b0001);
        run_traffic(150);
        check_counters();
        axil_write(xpt_pkg::ADDR_CNT_BASE + 4, 32'h0000_ffff, 4'hf, 0, resp);
        check_value(resp, xpt_pkg::RESP_SLVERR, "counter write resp");
        check_counters();
        axil_read(5'h14, 0, data, resp);
        check_value(data, 32'h0, "unmapped read data");
        check_value(resp, xpt_pkg::RESP_SLVERR, "unmapped read resp");
        // bus stalls while traffic keeps flowing
        @(posedge clk);
        traffic_on = 1'b1;
        for (int k = 0; k < 6; k++) begin
            rng_ctl = xorshift(rng_ctl);
            axil_read(xpt_pkg::ADDR_SELECT, 1 + rng_ctl[2:0], data, resp);
            check_value(data, {24'h0, exp_sel}, "select under back-pressure");
            check_value(resp, xpt_pkg::RESP_OKAY, "select read resp");
            axil_write(xpt_pkg::ADDR_SELECT, {rng_ctl[31:8], exp_sel}, 4'hf,
                       1 + rng_ctl[6:4], resp);
            check_value(resp, xpt_pkg::RESP_OKAY, "select rewrite resp");
            axil_read(5'h18, 1 + rng_ctl[10:8], data, resp);
            check_value(data, 32'h0, "unmapped read data");
            check_value(resp, xpt_pkg::RESP_SLVERR, "unmapped read resp");
        end
        @(posedge clk);
        traffic_on = 1'b0;
        repeat (4) @(posedge clk);
        check_counters();
        $display("Checks done with %0d errors", errors);
        if (errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

// File: bench/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter real PERIOD_NS    = 40.0,
    parameter int  RESET_CYCLES = 2
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

    // synchronous reset, released just after an edge
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst = 1'b0;
    end

endmodule

// File: source/axis_switch_top.sv
`timescale 1ns/1ps

module axis_switch_top #(
    parameter int S_COUNT    = 4,
    parameter int M_COUNT    = 4,
    parameter int DATA_WIDTH = 8,
    parameter int USER_WIDTH = 1
) (
    input  logic                                clk,
    input  logic                                rst,

    // stream inputs
    input  logic [S_COUNT*DATA_WIDTH-1:0]       s_axis_tdata,
    input  logic [S_COUNT-1:0]                  s_axis_tvalid,
    input  logic [S_COUNT-1:0]                  s_axis_tlast,
    input  logic [S_COUNT*USER_WIDTH-1:0]       s_axis_tuser,

    // stream outputs
    output logic [M_COUNT*DATA_WIDTH-1:0]       m_axis_tdata,
    output logic [M_COUNT-1:0]                  m_axis_tvalid,
    output logic [M_COUNT-1:0]                  m_axis_tlast,
    output logic [M_COUNT*USER_WIDTH-1:0]       m_axis_tuser,

    // AXI4-Lite control
    input  logic [xpt_pkg::AXIL_ADDR_WIDTH-1:0] awaddr,
    input  logic                                awvalid,
    output logic                                awready,
    input  logic [31:0]                         wdata,
    input  logic [3:0]                          wstrb,
    input  logic                                wvalid,
    output logic                                wready,
    output logic [1:0]                          bresp,
    output logic                                bvalid,
    input  logic                                bready,
    input  logic [xpt_pkg::AXIL_ADDR_WIDTH-1:0] araddr,
    input  logic                                arvalid,
    output logic                                arready,
    output logic [31:0]                         rdata,
    output logic [1:0]                          rresp,
    output logic                                rvalid,
    input  logic                                rready
);

    axis_if #(.DATA_WIDTH(DATA_WIDTH), .USER_WIDTH(USER_WIDTH)) s_bus [S_COUNT] ();
    axis_if #(.DATA_WIDTH(DATA_WIDTH), .USER_WIDTH(USER_WIDTH)) m_bus [M_COUNT] ();

    xpt_pkg::sel_word_u            select;
    logic [xpt_pkg::CNT_WIDTH-1:0] counts [M_COUNT];

    for (genvar gs = 0; gs < S_COUNT; gs++) begin : g_s_unpack
        assign s_bus[gs].tdata  = s_axis_tdata[gs*DATA_WIDTH +: DATA_WIDTH];
        assign s_bus[gs].tvalid = s_axis_tvalid[gs];
        assign s_bus[gs].tlast  = s_axis_tlast[gs];
        assign s_bus[gs].tuser  = s_axis_tuser[gs*USER_WIDTH +: USER_WIDTH];
    end

    axis_crosspoint #(
        .S_COUNT   (S_COUNT),
        .M_COUNT   (M_COUNT),
        .DATA_WIDTH(DATA_WIDTH),
        .USER_WIDTH(USER_WIDTH)
    ) xpt_i (
        .clk   (clk),
        .rst   (rst),
        .s_bus (s_bus),
        .m_bus (m_bus),
        .select(select)
    );

    // output packing and one frame counter per output
    for (genvar gm = 0; gm < M_COUNT; gm++) begin : g_m
        assign m_axis_tdata[gm*DATA_WIDTH +: DATA_WIDTH] = m_bus[gm].tdata;
        assign m_axis_tvalid[gm]                         = m_bus[gm].tvalid;
        assign m_axis_tlast[gm]                          = m_bus[gm].tlast;
        assign m_axis_tuser[gm*USER_WIDTH +: USER_WIDTH] = m_bus[gm].tuser;

        frame_counter cnt_i (
            .clk  (clk),
            .rst  (rst),
            .mon  (m_bus[gm]),
            .count(counts[gm])
        );
    end

    axil_switch_regs #(
        .M_COUNT(M_COUNT)
    ) regs_i (
        .clk    (clk),
        .rst    (rst),
        .awaddr (awaddr),
        .awvalid(awvalid),
        .awready(awready),
        .wdata  (wdata),
        .wstrb  (wstrb),
        .wvalid (wvalid),
        .wready (wready),
        .bresp  (bresp),
        .bvalid (bvalid),
        .bready (bready),
        .araddr (araddr),
        .arvalid(arvalid),
        .arready(arready),
        .rdata  (rdata),
        .rresp  (rresp),
        .rvalid (rvalid),
        .rready (rready),
        .counts (counts),
        .select (select)
    );

endmodule

// File: source/axil_switch_regs.sv
`timescale 1ns/1ps

module axil_switch_regs #(
    parameter int M_COUNT = 4
) (
    input  logic                                clk,
    input  logic                                rst,

    // write address
    input  logic [xpt_pkg::AXIL_ADDR_WIDTH-1:0] awaddr,
    input  logic                                awvalid,
    output logic                                awready,

    // write data
    input  logic [31:0]                         wdata,
    input  logic [3:0]                          wstrb,
    input  logic                                wvalid,
    output logic                                wready,

    // write response
    output logic [1:0]                          bresp,
    output logic                                bvalid,
    input  logic                                bready,

    // read address
    input  logic [xpt_pkg::AXIL_ADDR_WIDTH-1:0] araddr,
    input  logic                                arvalid,
    output logic                                arready,

    // read data
    output logic [31:0]                         rdata,
    output logic [1:0]                          rresp,
    output logic                                rvalid,
    input  logic                                rready,

    input  logic [xpt_pkg::CNT_WIDTH-1:0]       counts [M_COUNT],
    output xpt_pkg::sel_word_u                  select
);

    xpt_pkg::sel_word_u sel_q;
    xpt_pkg::sel_word_u sel_next;

    logic        wr_fire;
    logic        wr_hit;
    logic        rd_fire;
    logic        rd_hit;
    logic [31:0] rd_word;

    // accept address and data together, one outstanding response each
    assign wr_fire = awvalid && wvalid && !bvalid;
    assign awready = wr_fire;
    assign wready  = wr_fire;

    assign rd_fire = arvalid && !rvalid;
    assign arready = rd_fire;

    // only the select word is writable
    assign wr_hit = (awaddr == xpt_pkg::ADDR_SELECT);

    always_comb begin
        sel_next = sel_q;
        for (int b = 0; b < 4; b++) begin
            if (wstrb[b]) begin
                sel_next.raw[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        // pad bits do not hold state
        sel_next.fields.pad = '0;
    end

    always_comb begin
        rd_word = '0;
        rd_hit  = 1'b0;
        if (araddr == xpt_pkg::ADDR_SELECT) begin
            rd_word = sel_q.raw;
            rd_hit  = 1'b1;
        end
        for (int i = 0; i < M_COUNT; i++) begin
            if (araddr == xpt_pkg::ADDR_CNT_BASE + 4*i) begin
                rd_word = {{(32-xpt_pkg::CNT_WIDTH){1'b0}}, counts[i]};
                rd_hit  = 1'b1;
            end
        end
    end

    // write path
    always_ff @(posedge clk) begin
        if (rst) begin
            sel_q.raw <= '0;
            bvalid    <= 1'b0;
        end else if (wr_fire) begin
            bvalid <= 1'b1;
            if (wr_hit) begin
                sel_q <= sel_next;
            end
        end else if (bready) begin
            bvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            bresp <= wr_hit ? xpt_pkg::RESP_OKAY : xpt_pkg::RESP_SLVERR;
        end
    end

    // read path, response held until rready
    always_ff @(posedge clk) begin
        if (rst) begin
            rvalid <= 1'b0;
        end else if (rd_fire) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rdata <= rd_word;
            rresp <= rd_hit ? xpt_pkg::RESP_OKAY : xpt_pkg::RESP_SLVERR;
        end
    end

    assign select = sel_q;

endmodule

// File: source/frame_counter.sv
`timescale 1ns/1ps

module frame_counter (
    input  logic                          clk,
    input  logic                          rst,

    axis_if.sink                          mon,

    output logic [xpt_pkg::CNT_WIDTH-1:0] count
);

    logic [xpt_pkg::CNT_WIDTH-1:0] count_q;
    logic                          frame_end;

    // last beat of a frame
    assign frame_end = mon.tvalid && mon.tlast;

    // wraps at full width
    always_ff @(posedge clk) begin
        if (rst) begin
            count_q <= '0;
        end else if (frame_end) begin
            count_q <= count_q + 1'b1;
        end
    end

    assign count = count_q;

endmodule

// File: source/axis_crosspoint.sv
`timescale 1ns/1ps

module axis_crosspoint #(
    parameter int S_COUNT    = 4,
    parameter int M_COUNT    = 4,
    parameter int DATA_WIDTH = 8,
    parameter int USER_WIDTH = 1
) (
    input  logic              clk,
    input  logic              rst,

    axis_if.sink              s_bus [S_COUNT],
    axis_if.source            m_bus [M_COUNT],

    input  xpt_pkg::sel_word_u select
);

    // input stage
    logic [DATA_WIDTH-1:0] s_data_q  [S_COUNT];
    logic                  s_valid_q [S_COUNT];
    logic                  s_last_q  [S_COUNT];
    logic [USER_WIDTH-1:0] s_user_q  [S_COUNT];

    // output stage
    logic [DATA_WIDTH-1:0] m_data_q  [M_COUNT];
    logic                  m_valid_q [M_COUNT];
    logic                  m_last_q  [M_COUNT];
    logic [USER_WIDTH-1:0] m_user_q  [M_COUNT];

    xpt_pkg::sel_word_u select_q;
    logic [xpt_pkg::SEL_FIELD_WIDTH-1:0] sel_field [4];

    always_ff @(posedge clk) begin
        select_q <= select;
    end

    assign sel_field[0] = select_q.fields.sel0;
    assign sel_field[1] = select_q.fields.sel1;
    assign sel_field[2] = select_q.fields.sel2;
    assign sel_field[3] = select_q.fields.sel3;

    for (genvar gs = 0; gs < S_COUNT; gs++) begin : g_in
        always_ff @(posedge clk) begin
            if (rst) begin
                s_valid_q[gs] <= 1'b0;
            end else begin
                s_valid_q[gs] <= s_bus[gs].tvalid;
            end
            s_data_q[gs] <= s_bus[gs].tdata;
            s_last_q[gs] <= s_bus[gs].tlast;
            s_user_q[gs] <= s_bus[gs].tuser;
        end
    end

    for (genvar gm = 0; gm < M_COUNT; gm++) begin : g_out
        // pick the registered input named by this output's field
        always_ff @(posedge clk) begin
            if (rst) begin
                m_valid_q[gm] <= 1'b0;
            end else begin
                m_valid_q[gm] <= s_valid_q[sel_field[gm]];
            end
            m_data_q[gm] <= s_data_q[sel_field[gm]];
            m_last_q[gm] <= s_last_q[sel_field[gm]];
            m_user_q[gm] <= s_user_q[sel_field[gm]];
        end

        assign m_bus[gm].tdata  = m_data_q[gm];
        assign m_bus[gm].tvalid = m_valid_q[gm];
        assign m_bus[gm].tlast  = m_last_q[gm];
        assign m_bus[gm].tuser  = m_user_q[gm];
    end

endmodule

// File: source/axis_if.sv
`timescale 1ns/1ps

// stream without tready, a beat moves on every cycle with tvalid high
interface axis_if #(
    parameter int DATA_WIDTH = 8,
    parameter int USER_WIDTH = 1
) ();

    logic [DATA_WIDTH-1:0] tdata;
    logic                  tvalid;
    logic                  tlast;
    logic [USER_WIDTH-1:0] tuser;

    modport source (
        output tdata,
        output tvalid,
        output tlast,
        output tuser
    );

    modport sink (
        input tdata,
        input tvalid,
        input tlast,
        input tuser
    );

endinterface

// File: source/xpt_pkg.sv
package xpt_pkg;

    // one routing field per output
    localparam int SEL_FIELD_WIDTH = 2;

    // per-output frame counter width
    localparam int CNT_WIDTH = 16;

    localparam int AXIL_ADDR_WIDTH = 5;

    // register map
    localparam logic [AXIL_ADDR_WIDTH-1:0] ADDR_SELECT   = 5'h00;
    localparam logic [AXIL_ADDR_WIDTH-1:0] ADDR_CNT_BASE = 5'h04;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // select register, seen as a bus word or as routing fields
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [23:0]                pad;
            logic [SEL_FIELD_WIDTH-1:0] sel3;
            logic [SEL_FIELD_WIDTH-1:0] sel2;
            logic [SEL_FIELD_WIDTH-1:0] sel1;
            logic [SEL_FIELD_WIDTH-1:0] sel0;
        } fields;
    } sel_word_u;

endpackage
